//--- rtl/rename_pkg.sv
// Widths and types shared by the register-rename stage.
// Every block refers to these by scoped name, so the tag and index
// widths change in one place only.

`default_nettype none

package rename_pkg;

  localparam int NUM_AREGS = 32;  // Architectural registers, all renamed.
  localparam int NUM_PREGS = 64;  // Physical tags.

  // Architectural register index.
  typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;

  // Physical register tag.
  typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;

  // One map or checkpoint entry.
  // Top bit is the ready bit, the rest is the tag.
  typedef logic [$bits(preg_t):0] mt_entry_t;

  // Free-list pointer: slot index plus one wrap bit.
  // The list holds the tags not mapped after reset.
  typedef logic [$clog2(NUM_PREGS - NUM_AREGS):0] fl_ptr_t;

endpackage

`default_nettype wire

//--- rtl/map_table.sv
// Architectural-to-physical map with a ready bit per entry.
// Operand and old-destination reads are combinational in the dispatch
// cycle; renames, CDB ready sets and rollback loads land at the next edge.
// bak_data_o carries the next state, so a branch checkpoint includes
// the branch's own rename.

`default_nettype none

module map_table (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 dispatch_en_i,  // Rename strobe.
  input  rename_pkg::areg_t                                    opa_areg_i,
  input  rename_pkg::areg_t                                    opb_areg_i,
  input  rename_pkg::areg_t                                    dest_areg_i,
  input  rename_pkg::preg_t                                    new_preg_i,     // Free-list head.
  input  logic                                                 cdb_en_i,
  input  rename_pkg::preg_t                                    cdb_preg_i,
  input  logic                                                 rollback_i,
  input  rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0]    rc_data_i,      // Oldest checkpoint.
  output rename_pkg::preg_t                                    opa_preg_o,
  output rename_pkg::preg_t                                    opb_preg_o,
  output rename_pkg::preg_t                                    dest_old_preg_o,
  output logic                                                 opa_rdy_o,
  output logic                                                 opb_rdy_o,
  output rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0]    bak_data_o      // Next map state.
);

  localparam int RDY_BIT = $bits(rename_pkg::preg_t);  // Ready sits above the tag.

  rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0] map_q;  // Current map.
  rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0] map_d;  // Map after this cycle.
  logic [rename_pkg::NUM_AREGS-1:0] cdb_hit;                  // Entries holding the CDB tag.

  // Tags in the map are unique, so at most one entry hits.
  always_comb begin
    for (int i = 0; i < rename_pkg::NUM_AREGS; i++) begin
      cdb_hit[i] = cdb_en_i && (map_q[i][RDY_BIT-1:0] == cdb_preg_i);
    end
  end

  // Operand reads.
  // A broadcast in this very cycle is bypassed into the ready bits.
  assign opa_preg_o      = map_q[opa_areg_i][RDY_BIT-1:0];
  assign opb_preg_o      = map_q[opb_areg_i][RDY_BIT-1:0];
  assign opa_rdy_o       = map_q[opa_areg_i][RDY_BIT] | cdb_hit[opa_areg_i];
  assign opb_rdy_o       = map_q[opb_areg_i][RDY_BIT] | cdb_hit[opb_areg_i];
  assign dest_old_preg_o = map_q[dest_areg_i][RDY_BIT-1:0];  // Goes to the ROB.

  // Next-state map.
  // Priority from low to high: CDB set, dispatch rename, rollback.
  always_comb begin
    map_d = map_q;
    for (int i = 0; i < rename_pkg::NUM_AREGS; i++) begin
      if (cdb_hit[i]) begin
        map_d[i][RDY_BIT] = 1'b1;  // Producer has broadcast.
      end
    end
    if (dispatch_en_i) begin
      map_d[dest_areg_i] = {1'b0, new_preg_i};  // New tag, value not yet produced.
    end
    if (rollback_i) begin
      map_d = rc_data_i;  // Whole map from the checkpoint.
    end
  end

  assign bak_data_o = map_d;  // Saved by the branch stack on a branch dispatch.

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, everything ready.
      for (int i = 0; i < rename_pkg::NUM_AREGS; i++) begin
        map_q[i] <= {1'b1, rename_pkg::preg_t'(i)};
      end
    end else begin
      map_q <= map_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/free_list.sv
// Circular queue of free physical tags.
// Dispatch pops the head and retirement pushes old tags at the tail.
// A misprediction restores the read pointer from the checkpoint, which
// returns every tag handed out since the branch; the write pointer is
// left alone so retirements in the meantime are kept.

`default_nettype none

module free_list (
  input  logic                clk,
  input  logic                rst,
  input  logic                pop_i,        // Dispatch takes the head.
  input  logic                push_i,       // Retirement frees a tag.
  input  rename_pkg::preg_t   push_preg_i,
  input  logic                rollback_i,
  input  rename_pkg::fl_ptr_t rc_head_i,    // Saved read pointer.
  output rename_pkg::preg_t   head_preg_o,  // Next free tag.
  output rename_pkg::fl_ptr_t next_head_o,  // Read pointer after this cycle's pop.
  output logic                empty_o
);

  localparam int FL_SLOTS = rename_pkg::NUM_PREGS - rename_pkg::NUM_AREGS;
  localparam int IDX_W    = $clog2(FL_SLOTS);

  rename_pkg::preg_t   slots [FL_SLOTS];  // Tag storage.
  rename_pkg::fl_ptr_t rd_ptr;            // Head, wrap bit on top.
  rename_pkg::fl_ptr_t wr_ptr;            // Tail.

  // Same slot and same wrap means nothing left.
  assign empty_o = (rd_ptr == wr_ptr);

  assign head_preg_o = slots[rd_ptr[IDX_W-1:0]];
  assign next_head_o = pop_i ? rd_ptr + 1'b1 : rd_ptr;  // Checkpoint sees the branch's pop.

  always_ff @(posedge clk) begin
    if (rst) begin
      // Tags above the architectural range start out free, in order.
      for (int i = 0; i < FL_SLOTS; i++) begin
        slots[i] <= rename_pkg::preg_t'(rename_pkg::NUM_AREGS + i);
      end
      rd_ptr <= '0;
      wr_ptr <= rename_pkg::fl_ptr_t'(FL_SLOTS);  // Full: wrap bit differs.
    end else begin
      if (push_i) begin
        slots[wr_ptr[IDX_W-1:0]] <= push_preg_i;
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rollback_i) begin
        rd_ptr <= rc_head_i;  // Reclaim tags taken after the branch.
      end else begin
        rd_ptr <= next_head_o;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/branch_stack.sv
// In-order queue of branch checkpoints.
// Each entry is a copy of the map plus the free-list read pointer.
// Branches resolve oldest first, so recovery always uses the head entry.
// Broadcasts keep the stored ready bits current so a restore is not stale.

`default_nettype none

module branch_stack #(
  parameter int BR_DEPTH = 4  // Checkpoints held.
) (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               save_i,       // Branch dispatch.
  input  rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0]  save_data_i,
  input  rename_pkg::fl_ptr_t                                save_head_i,
  input  logic                                               resolve_i,    // Oldest resolves.
  input  logic                                               wrong_i,      // Mispredicted.
  input  logic                                               cdb_en_i,
  input  rename_pkg::preg_t                                  cdb_preg_i,
  output rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0]  rc_data_o,    // Oldest map copy.
  output rename_pkg::fl_ptr_t                                rc_head_o,
  output logic                                               full_o
);

  localparam int PTR_W   = (BR_DEPTH > 1) ? $clog2(BR_DEPTH) : 1;
  localparam int CNT_W   = $clog2(BR_DEPTH + 1);
  localparam int RDY_BIT = $bits(rename_pkg::preg_t);

  rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0] ck_map [BR_DEPTH];
  rename_pkg::fl_ptr_t ck_head [BR_DEPTH];

  logic [PTR_W-1:0] old_ptr;  // Oldest checkpoint.
  logic [PTR_W-1:0] new_ptr;  // Next slot to fill.
  logic [CNT_W-1:0] count;    // Entries in use.
  logic             do_pop;
  logic             flush;

  // Pointer step with wrap at BR_DEPTH.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(BR_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign flush  = resolve_i && wrong_i;                      // Discard every checkpoint.
  assign do_pop = resolve_i && !wrong_i && (count != '0);  // Correct prediction.
  assign full_o = (count == CNT_W'(BR_DEPTH));

  assign rc_data_o = ck_map[old_ptr];
  assign rc_head_o = ck_head[old_ptr];

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      old_ptr <= '0;
      new_ptr <= '0;
      count   <= '0;
    end else begin
      if (save_i) begin
        new_ptr <= ptr_inc(new_ptr);
      end
      if (do_pop) begin
        old_ptr <= ptr_inc(old_ptr);
      end
      count <= count + CNT_W'(save_i) - CNT_W'(do_pop);  // Save and pop may coincide.
    end
  end

  // Checkpoint payload.
  // Free slots are updated by the CDB too, which does no harm.
  always_ff @(posedge clk) begin
    if (cdb_en_i) begin
      for (int s = 0; s < BR_DEPTH; s++) begin
        for (int e = 0; e < rename_pkg::NUM_AREGS; e++) begin
          if (ck_map[s][e][RDY_BIT-1:0] == cdb_preg_i) begin
            ck_map[s][e][RDY_BIT] <= 1'b1;
          end
        end
      end
    end
    // New copy already includes this cycle's broadcast.
    if (save_i) begin
      ck_map[new_ptr]  <= save_data_i;
      ck_head[new_ptr] <= save_head_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rename_unit.sv
// Register-rename stage top level.
// Joins the map table, the free list and the branch checkpoint queue.
// Drive one dispatch per cycle while rename_stall_o is low; results come
// back combinationally in the same cycle.

`default_nettype none

module rename_unit #(
  parameter int BR_DEPTH = 4  // Unresolved branches allowed.
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              dispatch_en_i,
  input  logic              is_branch_i,
  input  rename_pkg::areg_t opa_areg_i,
  input  rename_pkg::areg_t opb_areg_i,
  input  rename_pkg::areg_t dest_areg_i,
  input  logic              cdb_en_i,
  input  rename_pkg::preg_t cdb_preg_i,
  input  logic              retire_en_i,
  input  rename_pkg::preg_t retire_preg_i,    // Old tag released by the ROB.
  input  logic              br_resolve_i,
  input  logic              br_wrong_i,
  output rename_pkg::preg_t opa_preg_o,
  output rename_pkg::preg_t opb_preg_o,
  output logic              opa_rdy_o,
  output logic              opb_rdy_o,
  output rename_pkg::preg_t dest_preg_o,      // New tag.
  output rename_pkg::preg_t dest_old_preg_o,
  output logic              rename_stall_o
);

  rename_pkg::preg_t   head_preg;
  rename_pkg::fl_ptr_t next_head;
  rename_pkg::fl_ptr_t rc_head;
  rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0] bak_data;
  rename_pkg::mt_entry_t [rename_pkg::NUM_AREGS-1:0] rc_data;
  logic fl_empty;
  logic bs_full;
  logic br_rollback;

  assign br_rollback    = br_resolve_i && br_wrong_i;
  assign rename_stall_o = fl_empty | bs_full;  // No tag or no checkpoint slot.
  assign dest_preg_o    = head_preg;

  map_table u_map_table (
    .clk, .rst, .dispatch_en_i, .opa_areg_i, .opb_areg_i, .dest_areg_i,
    .new_preg_i(head_preg), .cdb_en_i, .cdb_preg_i, .rollback_i(br_rollback),
    .rc_data_i(rc_data), .opa_preg_o, .opb_preg_o, .dest_old_preg_o,
    .opa_rdy_o, .opb_rdy_o, .bak_data_o(bak_data)
  );

  free_list u_free_list (
    .clk, .rst, .pop_i(dispatch_en_i), .push_i(retire_en_i),
    .push_preg_i(retire_preg_i), .rollback_i(br_rollback), .rc_head_i(rc_head),
    .head_preg_o(head_preg), .next_head_o(next_head), .empty_o(fl_empty)
  );

  // Checkpoint taken on the branch's own dispatch edge.
  branch_stack #(.BR_DEPTH(BR_DEPTH)) u_branch_stack (
    .clk, .rst, .save_i(dispatch_en_i && is_branch_i), .save_data_i(bak_data),
    .save_head_i(next_head), .resolve_i(br_resolve_i), .wrong_i(br_rollback),
    .cdb_en_i, .cdb_preg_i, .rc_data_o(rc_data), .rc_head_o(rc_head),
    .full_o(bs_full)
  );

endmodule

`default_nettype wire

//--- tests/rename_tb.sv
// Testbench for the register-rename stage.
// A model of the map, the free list and the checkpoint queue predicts every output.
// Inputs change on the falling edge, and the checker compares a quarter period later.

`default_nettype none

module rename_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BR_DEPTH = 4;
  localparam int NREG     = rename_pkg::NUM_AREGS;

  logic clk;
  logic rst;
  logic dispatch_en, is_branch, cdb_en, retire_en, br_resolve, br_wrong;
  rename_pkg::areg_t opa_areg, opb_areg, dest_areg;
  rename_pkg::preg_t cdb_preg, retire_preg;
  rename_pkg::preg_t opa_preg, opb_preg, dest_preg, dest_old_preg;
  logic opa_rdy, opb_rdy, rename_stall;

  int m_tag [NREG];              // Model map.
  bit m_rdy [NREG];
  int m_free [$];                // Free tags with the head first.
  int alloc_hist [$];            // Every tag handed out in order.
  int old_q [$];                 // Old tags that may be retired.
  int ck_tag [BR_DEPTH][NREG];   // Checkpoints with the oldest at 0.
  bit ck_rdy [BR_DEPTH][NREG];
  int ck_len [BR_DEPTH];         // History length at the checkpoint.
  int ck_count;
  int last_dest;

  rename_pkg::preg_t exp_opa_tag, exp_opb_tag, exp_dest_tag, exp_old_tag;
  bit exp_opa_rdy, exp_opb_rdy, exp_stall, exp_disp, chk_en;

  rename_unit #(.BR_DEPTH(BR_DEPTH)) dut (
    .clk(clk), .rst(rst), .dispatch_en_i(dispatch_en), .is_branch_i(is_branch),
    .opa_areg_i(opa_areg), .opb_areg_i(opb_areg), .dest_areg_i(dest_areg),
    .cdb_en_i(cdb_en), .cdb_preg_i(cdb_preg), .retire_en_i(retire_en),
    .retire_preg_i(retire_preg), .br_resolve_i(br_resolve), .br_wrong_i(br_wrong),
    .opa_preg_o(opa_preg), .opb_preg_o(opb_preg), .opa_rdy_o(opa_rdy), .opb_rdy_o(opb_rdy),
    .dest_preg_o(dest_preg), .dest_old_preg_o(dest_old_preg), .rename_stall_o(rename_stall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Outputs have settled by the middle of the low phase.
  always @(negedge clk) begin
    #5;
    if (!rst && chk_en) begin
      assert (opa_preg === exp_opa_tag && opa_rdy === exp_opa_rdy)
        else report_error($sformatf("operand A %0d/%0b, expected %0d/%0b",
                                    opa_preg, opa_rdy, exp_opa_tag, exp_opa_rdy));
      assert (opb_preg === exp_opb_tag && opb_rdy === exp_opb_rdy)
        else report_error($sformatf("operand B %0d/%0b, expected %0d/%0b",
                                    opb_preg, opb_rdy, exp_opb_tag, exp_opb_rdy));
      assert (rename_stall === exp_stall)
        else report_error($sformatf("stall %0b, expected %0b", rename_stall, exp_stall));
      if (exp_disp) begin
        assert (dest_preg === exp_dest_tag)
          else report_error($sformatf("new tag %0d, expected %0d", dest_preg, exp_dest_tag));
        assert (dest_old_preg === exp_old_tag)
          else report_error($sformatf("old tag %0d, expected %0d", dest_old_preg, exp_old_tag));
      end
    end
  end

  function automatic int random_areg();
    return $urandom_range(NREG - 1);
  endfunction

  // Sets expectations, drives one cycle, advances the model and waits for the next falling edge.
  task automatic step(input bit disp, input bit br, input int a, input int b, input int d,
                      input bit cdb, input int ctag, input bit ret, input int rtag,
                      input bit res, input bit wrong);
    exp_opa_tag  = rename_pkg::preg_t'(m_tag[a]);
    exp_opb_tag  = rename_pkg::preg_t'(m_tag[b]);
    exp_opa_rdy  = m_rdy[a] || (cdb && m_tag[a] == ctag);  // CDB bypass.
    exp_opb_rdy  = m_rdy[b] || (cdb && m_tag[b] == ctag);
    exp_stall    = (m_free.size() == 0) || (ck_count == BR_DEPTH);
    exp_disp     = disp;
    exp_dest_tag = disp ? rename_pkg::preg_t'(m_free[0]) : '0;
    exp_old_tag  = rename_pkg::preg_t'(m_tag[d]);
    chk_en       = 1'b1;
    dispatch_en  = disp;
    is_branch    = br;
    opa_areg     = rename_pkg::areg_t'(a);
    opb_areg     = rename_pkg::areg_t'(b);
    dest_areg    = rename_pkg::areg_t'(d);
    cdb_en       = cdb;
    cdb_preg     = rename_pkg::preg_t'(ctag);
    retire_en    = ret;
    retire_preg  = rename_pkg::preg_t'(rtag);
    br_resolve   = res;
    br_wrong     = wrong;
    if (cdb) begin
      for (int i = 0; i < NREG; i++) begin
        if (m_tag[i] == ctag) m_rdy[i] = 1'b1;
        for (int s = 0; s < ck_count; s++) begin
          if (ck_tag[s][i] == ctag) ck_rdy[s][i] = 1'b1;  // Saved copies stay current.
        end
      end
    end
    if (res && wrong) begin
      m_tag = ck_tag[0];
      m_rdy = ck_rdy[0];
      while (alloc_hist.size() > ck_len[0]) m_free.push_front(alloc_hist.pop_back());
      ck_count = 0;  // Every checkpoint is discarded.
    end else begin
      if (res) begin
        for (int s = 1; s < ck_count; s++) begin
          ck_tag[s-1] = ck_tag[s];
          ck_rdy[s-1] = ck_rdy[s];
          ck_len[s-1] = ck_len[s];
        end
        ck_count--;
      end
      if (disp) begin
        old_q.push_back(m_tag[d]);
        m_tag[d] = m_free.pop_front();
        m_rdy[d] = 1'b0;
        alloc_hist.push_back(m_tag[d]);
        last_dest = d;
        if (br) begin
          ck_tag[ck_count] = m_tag;  // Includes the branch's own rename.
          ck_rdy[ck_count] = m_rdy;
          ck_len[ck_count] = alloc_hist.size();
          ck_count++;
        end
      end
    end
    if (ret) m_free.push_back(rtag);
    @(negedge clk);
  endtask

  task automatic idle_cycle();
    step(0, 0, random_areg(), random_areg(), 0, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic wait_no_stall(input int max_cycles);
    int n;
    n = 0;
    while (rename_stall && n < max_cycles) begin
      idle_cycle();
      n++;
    end
    if (rename_stall) report_timeout("rename_stall_o to drop");
  endtask

  task automatic dispatch_instr(input bit br);
    wait_no_stall(8);
    step(1, br, random_areg(), random_areg(), random_areg(), 0, 0, 0, 0, 0, 0);
  endtask

  task automatic retire_old();
    step(0, 0, random_areg(), random_areg(), 0, 0, 0, 1, old_q.pop_front(), 0, 0);
  endtask

  initial begin
    int r;
    int tag;
    void'($urandom(32'hadbeb03a));
    {dispatch_en, is_branch, cdb_en, retire_en, br_resolve, br_wrong, chk_en} = '0;
    {opa_areg, opb_areg, dest_areg, cdb_preg, retire_preg} = '0;
    for (int i = 0; i < NREG; i++) begin
      m_tag[i] = i;
      m_rdy[i] = 1'b1;
      m_free.push_back(NREG + i);  // Tags 32 to 63 in order.
    end
    ck_count = 0;
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NREG / 2; i++) begin
      step(0, 0, i, NREG - 1 - i, 0, 0, 0, 0, 0, 0, 0);  // Identity map with all entries ready.
    end
    repeat (12) dispatch_instr(1'b0);
    r = last_dest;
    tag = m_tag[r];
    step(0, 0, r, random_areg(), 0, 0, 0, 0, 0, 0, 0);    // New tag still waits for its value.
    step(0, 0, r, random_areg(), 0, 1, tag, 0, 0, 0, 0);  // Ready through the bypass.
    step(0, 0, random_areg(), r, 0, 0, 0, 0, 0, 0, 0);    // Ready from the map.
    repeat (6) begin
      wait_no_stall(8);
      step(1, 0, random_areg(), random_areg(), random_areg(), 1,
           alloc_hist[$urandom_range(alloc_hist.size() - 1)], 0, 0, 0, 0);
    end
    repeat (3) retire_old();
    while (m_free.size() > 0) dispatch_instr(1'b0);  // Run the list empty.
    idle_cycle();
    retire_old();
    dispatch_instr(1'b0);  // Retired tag comes back one cycle later.
    repeat (24) retire_old();
    dispatch_instr(1'b0);
    dispatch_instr(1'b1);
    r = last_dest;
    tag = m_tag[r];
    repeat (3) dispatch_instr(1'b0);
    step(0, 0, r, random_areg(), 0, 1, tag, 0, 0, 0, 0);  // Broadcast after the checkpoint.
    step(0, 0, random_areg(), random_areg(), 0, 0, 0, 0, 0, 1, 1);  // Mispredict.
    for (int i = 0; i < NREG / 2; i++) begin
      step(0, 0, i, NREG - 1 - i, 0, 0, 0, 0, 0, 0, 0);
    end
    dispatch_instr(1'b0);  // Gets the tag that followed the branch.
    for (int k = 0; k < BR_DEPTH; k++) begin
      dispatch_instr(1'b0);
      dispatch_instr(1'b1);
    end
    idle_cycle();  // Branch stack full.
    step(0, 0, random_areg(), random_areg(), 0, 0, 0, 0, 0, 1, 0);
    dispatch_instr(1'b1);
    repeat (BR_DEPTH) step(0, 0, random_areg(), random_areg(), 0, 0, 0, 0, 0, 1, 0);
    idle_cycle();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/branch_stack.sv
rtl/rename_unit.sv
tests/rename_tb.sv

//--- Makefile
SIM      = verilator
TOP      = rename_tb
FILELIST = sources.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
